// File: source/soc_macros.svh
// Bus widths, memory map windows, control register offsets and scratchpad size
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_BE_W   8
`define APB_DATA_W 32

// Memory map
`define DRAM_BASE 32'h8000_0000
`define DRAM_LEN  32'h0000_1000
`define UART_BASE 32'hC000_0000
`define UART_LEN  32'h0000_1000
`define CTRL_BASE 32'hD000_0000
`define CTRL_LEN  32'h0000_1000

// Scratchpad depth in 64-bit words
`define L2_WORDS 512

// Control register offsets within the window
`define CTRL_EXIT_OFS      12'h000
`define CTRL_DRAM_BASE_OFS 12'h008
`define CTRL_DRAM_END_OFS  12'h010

`endif

// File: source/soc_pkg.sv
// Package with the bus address union and the target-select enum
package soc_pkg;

  // Scratchpad view, 64-bit words
  typedef struct packed {
    logic [19:0] region;
    logic [8:0]  word_idx;
    logic [2:0]  byte_ofs;
  } dram_addr_t;

  // Peripheral view, 64-bit registers split into 32-bit halves
  typedef struct packed {
    logic [19:0] region;
    logic [8:0]  reg_idx;
    logic        half_sel;
    logic [1:0]  byte_ofs;
  } periph_addr_t;

  typedef union packed {
    dram_addr_t   dram;
    periph_addr_t periph;
  } soc_addr_u;

  typedef enum logic [1:0] {
    SEL_L2   = 2'd0,
    SEL_UART = 2'd1,
    SEL_CTRL = 2'd2,
    SEL_NONE = 2'd3
  } target_sel_e;

endpackage

// File: source/bus_arbiter.sv
// Round-robin arbiter for the core and vector ports with request and response muxing
`timescale 1ns/10ps
`include "soc_macros.svh"

module bus_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   core_req_i,
  input  logic                   core_we_i,
  input  logic [`SOC_ADDR_W-1:0] core_addr_i,
  input  logic [`SOC_DATA_W-1:0] core_wdata_i,
  input  logic [`SOC_BE_W-1:0]   core_be_i,
  output logic                   core_gnt_o,
  output logic                   core_rvalid_o,
  output logic [`SOC_DATA_W-1:0] core_rdata_o,
  output logic                   core_err_o,
  input  logic                   vec_req_i,
  input  logic                   vec_we_i,
  input  logic [`SOC_ADDR_W-1:0] vec_addr_i,
  input  logic [`SOC_DATA_W-1:0] vec_wdata_i,
  input  logic [`SOC_BE_W-1:0]   vec_be_i,
  output logic                   vec_gnt_o,
  output logic                   vec_rvalid_o,
  output logic [`SOC_DATA_W-1:0] vec_rdata_o,
  output logic                   vec_err_o,
  input  logic                   bus_done_i,
  input  logic [`SOC_DATA_W-1:0] bus_rdata_i,
  input  logic                   bus_err_i,
  output logic                   bus_sel_o,
  output logic                   bus_we_o,
  output logic [`SOC_ADDR_W-1:0] bus_addr_o,
  output logic [`SOC_DATA_W-1:0] bus_wdata_o,
  output logic [`SOC_BE_W-1:0]   bus_be_o
);

  logic busy_q, owner_q, last_q, sel_q;
  logic pick_vec, any_gnt;

  // last_q set means the vector port was served last
  assign pick_vec   = vec_req_i & (~core_req_i | ~last_q);
  assign core_gnt_o = ~busy_q & core_req_i & ~pick_vec;
  assign vec_gnt_o  = ~busy_q & pick_vec;
  assign any_gnt    = core_gnt_o | vec_gnt_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;
      sel_q   <= 1'b0;
    end else begin
      sel_q <= any_gnt;
      if (any_gnt) begin
        busy_q  <= 1'b1;
        owner_q <= pick_vec;
        last_q  <= pick_vec;
      end else if (bus_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Granted request, held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      bus_we_o    <= pick_vec ? vec_we_i    : core_we_i;
      bus_addr_o  <= pick_vec ? vec_addr_i  : core_addr_i;
      bus_wdata_o <= pick_vec ? vec_wdata_i : core_wdata_i;
      bus_be_o    <= pick_vec ? vec_be_i    : core_be_i;
    end
  end

  assign bus_sel_o = sel_q;

  // Response goes back to the owner only
  assign core_rvalid_o = busy_q & bus_done_i & ~owner_q;
  assign vec_rvalid_o  = busy_q & bus_done_i & owner_q;
  assign core_rdata_o  = owner_q ? '0 : bus_rdata_i;
  assign vec_rdata_o   = owner_q ? bus_rdata_i : '0;
  assign core_err_o    = core_rvalid_o & bus_err_i;
  assign vec_err_o     = vec_rvalid_o & bus_err_i;

  a_gnt_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(core_gnt_o && vec_gnt_o));

  // Targets never answer without an open transfer
  a_no_done_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_q |-> !bus_done_i);

endmodule

// File: source/addr_decoder.sv
// Address decoder with target strobes, response mux and decode-error response
`timescale 1ns/10ps
`include "soc_macros.svh"

module addr_decoder (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   bus_sel_i,
  input  logic [`SOC_ADDR_W-1:0] bus_addr_i,
  input  logic                   l2_done_i,
  input  logic [`SOC_DATA_W-1:0] l2_rdata_i,
  input  logic                   uart_done_i,
  input  logic [`SOC_DATA_W-1:0] uart_rdata_i,
  input  logic                   uart_err_i,
  input  logic                   ctrl_done_i,
  input  logic [`SOC_DATA_W-1:0] ctrl_rdata_i,
  input  logic                   ctrl_err_i,
  output logic                   l2_sel_o,
  output logic                   uart_sel_o,
  output logic                   ctrl_sel_o,
  output logic                   bus_done_o,
  output logic [`SOC_DATA_W-1:0] bus_rdata_o,
  output logic                   bus_err_o
);

  import soc_pkg::*;

  target_sel_e tgt_d, tgt_q;
  logic        miss_q;

  // First matching window wins
  always_comb begin
    if (bus_addr_i >= `DRAM_BASE && bus_addr_i < `DRAM_BASE + `DRAM_LEN) begin
      tgt_d = SEL_L2;
    end else if (bus_addr_i >= `UART_BASE && bus_addr_i < `UART_BASE + `UART_LEN) begin
      tgt_d = SEL_UART;
    end else if (bus_addr_i >= `CTRL_BASE && bus_addr_i < `CTRL_BASE + `CTRL_LEN) begin
      tgt_d = SEL_CTRL;
    end else begin
      tgt_d = SEL_NONE;
    end
  end

  assign l2_sel_o   = bus_sel_i && (tgt_d == SEL_L2);
  assign uart_sel_o = bus_sel_i && (tgt_d == SEL_UART);
  assign ctrl_sel_o = bus_sel_i && (tgt_d == SEL_CTRL);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tgt_q  <= SEL_NONE;
      miss_q <= 1'b0;
    end else begin
      miss_q <= bus_sel_i && (tgt_d == SEL_NONE);
      if (bus_sel_i) begin
        tgt_q <= tgt_d;
      end
    end
  end

  always_comb begin
    case (tgt_q)
      SEL_L2: begin
        bus_done_o  = l2_done_i;
        bus_rdata_o = l2_rdata_i;
        bus_err_o   = 1'b0;
      end
      SEL_UART: begin
        bus_done_o  = uart_done_i;
        bus_rdata_o = uart_rdata_i;
        bus_err_o   = uart_err_i;
      end
      SEL_CTRL: begin
        bus_done_o  = ctrl_done_i;
        bus_rdata_o = ctrl_rdata_i;
        bus_err_o   = ctrl_err_i;
      end
      default: begin
        bus_done_o  = miss_q;
        bus_rdata_o = '0;
        bus_err_o   = miss_q;
      end
    endcase
  end

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({l2_sel_o, uart_sel_o, ctrl_sel_o}));

endmodule

// File: source/l2_mem.sv
// Byte-enabled single-port scratchpad with one-cycle read response
`timescale 1ns/10ps
`include "soc_macros.svh"

module l2_mem #(
  parameter int unsigned NumWords = `L2_WORDS
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   sel_i,
  input  logic                   we_i,
  input  soc_pkg::soc_addr_u     addr_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`SOC_BE_W-1:0]   be_i,
  output logic                   done_o,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  logic [`SOC_DATA_W-1:0] mem_q [NumWords];
  logic                   done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        for (int b = 0; b < `SOC_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i.dram.word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[addr_i.dram.word_idx];
      end
    end
  end

  assign done_o = done_q;

endmodule

// File: source/uart_apb_bridge.sv
// Bus to APB bridge toward the UART with setup and access phases
`timescale 1ns/10ps
`include "soc_macros.svh"

module uart_apb_bridge (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   sel_i,
  input  logic                   we_i,
  input  soc_pkg::soc_addr_u     addr_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`APB_DATA_W-1:0] prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i,
  output logic                   done_o,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   err_o,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [`SOC_ADDR_W-1:0] paddr_o,
  output logic [`APB_DATA_W-1:0] pwdata_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} apb_state_e;

  apb_state_e state_q;
  logic       pwrite_q, done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      pwrite_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (sel_i) begin
            state_q  <= ST_SETUP;
            pwrite_q <= we_i;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          // Slave may stretch the access phase
          if (pready_i) begin
            state_q  <= ST_IDLE;
            pwrite_q <= 1'b0;
            done_q   <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && sel_i) begin
      paddr_o  <= addr_i;
      pwdata_o <= addr_i.periph.half_sel ? wdata_i[63:32] : wdata_i[31:0];
    end
    if (state_q == ST_ACCESS && pready_i) begin
      rdata_o <= pwrite_q ? '0 : {prdata_i, prdata_i};
      err_o   <= pslverr_i;
    end
  end

  assign psel_o    = state_q != ST_IDLE;
  assign penable_o = state_q == ST_ACCESS;
  assign pwrite_o  = pwrite_q;
  assign done_o    = done_q;

  // Access phase always follows a setup cycle
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_o |-> psel_o && $past(psel_o));

endmodule

// File: source/ctrl_regs.sv
// Control registers with the exit word and read-only DRAM base and end
`timescale 1ns/10ps
`include "soc_macros.svh"

module ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   sel_i,
  input  logic                   we_i,
  input  soc_pkg::soc_addr_u     addr_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`SOC_BE_W-1:0]   be_i,
  output logic                   done_o,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   err_o,
  output logic [63:0]            exit_o
);

  logic [11:0] reg_ofs;
  logic        is_exit, is_base, is_end;
  logic        done_q;
  logic [63:0] exit_q;

  assign reg_ofs = {addr_i.periph.reg_idx, 3'b000};
  assign is_exit = reg_ofs == `CTRL_EXIT_OFS;
  assign is_base = reg_ofs == `CTRL_DRAM_BASE_OFS;
  assign is_end  = reg_ofs == `CTRL_DRAM_END_OFS;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
      exit_q <= '0;
    end else begin
      done_q <= sel_i;
      if (sel_i && we_i && is_exit) begin
        for (int b = 0; b < `SOC_BE_W; b++) begin
          if (be_i[b]) begin
            exit_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Only the exit register takes writes
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      err_o <= we_i ? !is_exit : !(is_exit || is_base || is_end);
      if (we_i || is_exit) begin
        rdata_o <= we_i ? '0 : exit_q;
      end else if (is_base) begin
        rdata_o <= 64'(`DRAM_BASE);
      end else if (is_end) begin
        rdata_o <= 64'(`DRAM_BASE + `DRAM_LEN);
      end else begin
        rdata_o <= '0;
      end
    end
  end

  assign done_o = done_q;
  assign exit_o = exit_q;

endmodule

// File: source/soc_top.sv
// Top level of the bus fabric with arbiter, decoder, scratchpad, UART bridge and control registers
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   core_req_i,
  input  logic                   core_we_i,
  input  logic [`SOC_ADDR_W-1:0] core_addr_i,
  input  logic [`SOC_DATA_W-1:0] core_wdata_i,
  input  logic [`SOC_BE_W-1:0]   core_be_i,
  output logic                   core_gnt_o,
  output logic                   core_rvalid_o,
  output logic [`SOC_DATA_W-1:0] core_rdata_o,
  output logic                   core_err_o,
  input  logic                   vec_req_i,
  input  logic                   vec_we_i,
  input  logic [`SOC_ADDR_W-1:0] vec_addr_i,
  input  logic [`SOC_DATA_W-1:0] vec_wdata_i,
  input  logic [`SOC_BE_W-1:0]   vec_be_i,
  output logic                   vec_gnt_o,
  output logic                   vec_rvalid_o,
  output logic [`SOC_DATA_W-1:0] vec_rdata_o,
  output logic                   vec_err_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [`APB_DATA_W-1:0] uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i,
  output logic [63:0]            exit_o
);

  // Shared bus after arbitration
  logic                   bus_sel, bus_we, bus_done, bus_err;
  logic [`SOC_ADDR_W-1:0] bus_addr;
  logic [`SOC_DATA_W-1:0] bus_wdata, bus_rdata;
  logic [`SOC_BE_W-1:0]   bus_be;

  // Per-target strobes and responses
  logic                   l2_sel, l2_done;
  logic [`SOC_DATA_W-1:0] l2_rdata;
  logic                   uart_sel, uart_done, uart_err;
  logic [`SOC_DATA_W-1:0] uart_rdata;
  logic                   ctrl_sel, ctrl_done, ctrl_err;
  logic [`SOC_DATA_W-1:0] ctrl_rdata;

  bus_arbiter i_bus_arbiter (
    .clk_i, .rst_n_i,
    .core_req_i, .core_we_i, .core_addr_i, .core_wdata_i, .core_be_i,
    .core_gnt_o, .core_rvalid_o, .core_rdata_o, .core_err_o,
    .vec_req_i, .vec_we_i, .vec_addr_i, .vec_wdata_i, .vec_be_i,
    .vec_gnt_o, .vec_rvalid_o, .vec_rdata_o, .vec_err_o,
    .bus_done_i (bus_done),  .bus_rdata_i(bus_rdata), .bus_err_i(bus_err),
    .bus_sel_o  (bus_sel),   .bus_we_o   (bus_we),    .bus_addr_o(bus_addr),
    .bus_wdata_o(bus_wdata), .bus_be_o   (bus_be)
  );

  addr_decoder i_addr_decoder (
    .clk_i, .rst_n_i,
    .bus_sel_i   (bus_sel),    .bus_addr_i  (bus_addr),
    .l2_done_i   (l2_done),    .l2_rdata_i  (l2_rdata),
    .uart_done_i (uart_done),  .uart_rdata_i(uart_rdata), .uart_err_i(uart_err),
    .ctrl_done_i (ctrl_done),  .ctrl_rdata_i(ctrl_rdata), .ctrl_err_i(ctrl_err),
    .l2_sel_o    (l2_sel),     .uart_sel_o  (uart_sel),   .ctrl_sel_o(ctrl_sel),
    .bus_done_o  (bus_done),   .bus_rdata_o (bus_rdata),  .bus_err_o (bus_err)
  );

  l2_mem i_l2_mem (
    .clk_i, .rst_n_i,
    .sel_i(l2_sel), .we_i(bus_we), .addr_i(bus_addr), .wdata_i(bus_wdata), .be_i(bus_be),
    .done_o(l2_done), .rdata_o(l2_rdata)
  );

  uart_apb_bridge i_uart_apb_bridge (
    .clk_i, .rst_n_i,
    .sel_i(uart_sel), .we_i(bus_we), .addr_i(bus_addr), .wdata_i(bus_wdata),
    .prdata_i(uart_prdata_i), .pready_i(uart_pready_i), .pslverr_i(uart_pslverr_i),
    .done_o(uart_done), .rdata_o(uart_rdata), .err_o(uart_err),
    .psel_o(uart_psel_o), .penable_o(uart_penable_o), .pwrite_o(uart_pwrite_o),
    .paddr_o(uart_paddr_o), .pwdata_o(uart_pwdata_o)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i, .rst_n_i,
    .sel_i(ctrl_sel), .we_i(bus_we), .addr_i(bus_addr), .wdata_i(bus_wdata), .be_i(bus_be),
    .done_o(ctrl_done), .rdata_o(ctrl_rdata), .err_o(ctrl_err), .exit_o
  );

endmodule

// File: test/apb_uart_model.sv
// APB responder for the UART port with inverted-address read data and one wait state
`timescale 1ns/10ps

module apb_uart_model (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        last_pwrite_o,
  output logic [31:0] last_paddr_o,
  output logic [31:0] last_pwdata_o
);

  logic waited_q;

  assign pready_o  = psel_i && penable_i && waited_q;
  assign pslverr_o = pready_o && (paddr_i[11:0] == 12'hffc);
  assign prdata_o  = ~paddr_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      waited_q      <= 1'b0;
      last_pwrite_o <= 1'b0;
      last_paddr_o  <= '0;
      last_pwdata_o <= '0;
    end else begin
      // One wait state in every access phase
      waited_q <= psel_i && penable_i && !waited_q;
      if (pready_o) begin
        last_pwrite_o <= pwrite_i;
        last_paddr_o  <= paddr_i;
        last_pwdata_o <= pwdata_i;
      end
    end
  end

endmodule

// File: test/soc_top_tb.sv
// Testbench for the bus fabric with a stimulus table, response checks and a summary
`timescale 1ns/10ps

module soc_top_tb;

  localparam int wait_limit = 100;

  logic        clk, rst_n;
  logic        core_req, core_we, vec_req, vec_we;
  logic [31:0] core_addr, vec_addr;
  logic [63:0] core_wdata, vec_wdata;
  logic [7:0]  core_be, vec_be;
  logic        core_gnt, core_rvalid, core_err, vec_gnt, vec_rvalid, vec_err;
  logic [63:0] core_rdata, vec_rdata, exit_val;
  logic        psel, penable, pwrite, pready, pslverr, last_pwrite;
  logic [31:0] paddr, pwdata, prdata, last_paddr, last_pwdata;

  // Stimulus table, one entry per transfer
  string       name_q[$];
  int          master_q[$], side_q[$];
  logic        we_q[$], exp_err_q[$];
  logic [31:0] addr_q[$];
  logic [63:0] wdata_q[$], exp_rdata_q[$], exp_side_q[$];
  logic [7:0]  be_q[$];

  integer      seed;
  int          run_cnt, fail_cnt;
  bit          hung;
  logic [63:0] w0, w1, w2, w3, w4, w5;

  soc_top uut (
    .clk_i(clk), .rst_n_i(rst_n),
    .core_req_i(core_req), .core_we_i(core_we), .core_addr_i(core_addr),
    .core_wdata_i(core_wdata), .core_be_i(core_be),
    .core_gnt_o(core_gnt), .core_rvalid_o(core_rvalid), .core_rdata_o(core_rdata),
    .core_err_o(core_err),
    .vec_req_i(vec_req), .vec_we_i(vec_we), .vec_addr_i(vec_addr),
    .vec_wdata_i(vec_wdata), .vec_be_i(vec_be),
    .vec_gnt_o(vec_gnt), .vec_rvalid_o(vec_rvalid), .vec_rdata_o(vec_rdata),
    .vec_err_o(vec_err),
    .uart_psel_o(psel), .uart_penable_o(penable), .uart_pwrite_o(pwrite),
    .uart_paddr_o(paddr), .uart_pwdata_o(pwdata),
    .uart_prdata_i(prdata), .uart_pready_i(pready), .uart_pslverr_i(pslverr),
    .exit_o(exit_val)
  );

  apb_uart_model i_uart_model (
    .clk_i(clk), .rst_n_i(rst_n),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .last_pwrite_o(last_pwrite), .last_paddr_o(last_paddr), .last_pwdata_o(last_pwdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                               input logic [63:0] new_w,
                                               input logic [7:0] be);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic add_test(input string name, input int master, input logic we,
                          input logic [31:0] addr, input logic [63:0] wdata,
                          input logic [7:0] be, input logic [63:0] exp_rdata,
                          input logic exp_err, input int side, input logic [63:0] exp_side);
    name_q.push_back(name);
    master_q.push_back(master);
    we_q.push_back(we);
    addr_q.push_back(addr);
    wdata_q.push_back(wdata);
    be_q.push_back(be);
    exp_rdata_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    side_q.push_back(side);
    exp_side_q.push_back(exp_side);
  endtask

  task automatic drive_req(input int m, input int idx);
    if (m == 1) begin
      vec_req   <= 1'b1;
      vec_we    <= we_q[idx];
      vec_addr  <= addr_q[idx];
      vec_wdata <= wdata_q[idx];
      vec_be    <= be_q[idx];
    end else begin
      core_req   <= 1'b1;
      core_we    <= we_q[idx];
      core_addr  <= addr_q[idx];
      core_wdata <= wdata_q[idx];
      core_be    <= be_q[idx];
    end
  endtask

  task automatic drop_req(input int m);
    if (m == 1) begin
      vec_req <= 1'b0;
    end else begin
      core_req <= 1'b0;
    end
  endtask

  // Strobes and exit word right after reset release
  task automatic check_reset_state();
    bit         bad;
    logic [6:0] strobes;
    bad = 1'b0;
    @(negedge clk);
    strobes = {core_gnt, core_rvalid, vec_gnt, vec_rvalid, psel, penable, pwrite};
    assert (strobes === 7'b0) else begin
      $display("Error reset_state strobes: expected %b, actual %b", 7'b0, strobes);
      bad = 1'b1;
    end
    assert (exit_val === 64'h0) else begin
      $display("Error reset_state exit: expected %h, actual %h", 64'h0, exit_val);
      bad = 1'b1;
    end
    $display("%-14s %s", "reset_state", bad ? "FAIL" : "ok");
    run_cnt++;
    if (bad) begin
      fail_cnt++;
    end
  endtask

  // m of 2 accepts a grant on either port
  task automatic wait_gnt(input int m, input int idx, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < wait_limit) begin
      @(negedge clk);
      seen = (m == 1) ? vec_gnt : (m == 0) ? core_gnt : (core_gnt | vec_gnt);
      n++;
    end
    if (!seen) begin
      $display("Test %s timed out waiting for a grant", name_q[idx]);
      hung = 1'b1;
      run_cnt++;
      fail_cnt++;
    end
  endtask

  task automatic wait_rvalid(input int m, input int idx, output bit seen,
                             output logic [63:0] rdata, output logic err);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < wait_limit) begin
      @(negedge clk);
      seen = (m == 1) ? vec_rvalid : core_rvalid;
      n++;
    end
    rdata = (m == 1) ? vec_rdata : core_rdata;
    err   = (m == 1) ? vec_err : core_err;
    if (!seen) begin
      $display("Test %s timed out waiting for the response", name_q[idx]);
      hung = 1'b1;
      run_cnt++;
      fail_cnt++;
    end
  endtask

  task automatic check_resp(input int idx, input logic [63:0] rdata, input logic err,
                            input bit bad_in);
    bit bad;
    bad = bad_in;
    assert (rdata === exp_rdata_q[idx]) else begin
      $display("Error %s rdata: expected %h, actual %h", name_q[idx], exp_rdata_q[idx], rdata);
      bad = 1'b1;
    end
    assert (err === exp_err_q[idx]) else begin
      $display("Error %s err: expected %b, actual %b", name_q[idx], exp_err_q[idx], err);
      bad = 1'b1;
    end
    if (side_q[idx] == 1) begin
      assert (exit_val === exp_side_q[idx]) else begin
        $display("Error %s exit: expected %h, actual %h", name_q[idx], exp_side_q[idx],
                 exit_val);
        bad = 1'b1;
      end
    end else if (side_q[idx] == 2) begin
      assert (last_pwrite === 1'b1) else begin
        $display("Error %s pwrite: expected 1, actual %b", name_q[idx], last_pwrite);
        bad = 1'b1;
      end
      assert ({last_paddr, last_pwdata} === exp_side_q[idx]) else begin
        $display("Error %s paddr and pwdata: expected %h, actual %h", name_q[idx],
                 exp_side_q[idx], {last_paddr, last_pwdata});
        bad = 1'b1;
      end
    end
    $display("%-14s %s", name_q[idx], bad ? "FAIL" : "ok");
    run_cnt++;
    if (bad) begin
      fail_cnt++;
    end
  endtask

  task automatic run_one(input int idx);
    bit          seen;
    logic [63:0] rdata;
    logic        err;
    @(posedge clk);
    drive_req(master_q[idx], idx);
    wait_gnt(master_q[idx], idx, seen);
    if (seen) begin
      @(posedge clk);
      drop_req(master_q[idx]);
      wait_rvalid(master_q[idx], idx, seen, rdata, err);
    end
    if (seen) begin
      check_resp(idx, rdata, err, 1'b0);
    end
  endtask

  // Both ports request in the same cycle, the core entry comes first in the table
  task automatic run_pair(input int idx);
    bit          seen, order_bad;
    logic [63:0] rdata;
    logic        err;
    order_bad = 1'b0;
    @(posedge clk);
    drive_req(0, idx);
    drive_req(1, idx + 1);
    wait_gnt(2, idx, seen);
    if (seen) begin
      assert (core_gnt && !vec_gnt) else begin
        $display("Test %s: the vector port was granted before the core port", name_q[idx]);
        order_bad = 1'b1;
      end
      @(posedge clk);
      drop_req(0);
      wait_rvalid(0, idx, seen, rdata, err);
    end
    if (seen) begin
      check_resp(idx, rdata, err, order_bad);
      wait_gnt(1, idx + 1, seen);
    end
    if (seen) begin
      @(posedge clk);
      drop_req(1);
      wait_rvalid(1, idx + 1, seen, rdata, err);
    end
    if (seen) begin
      check_resp(idx + 1, rdata, err, 1'b0);
    end
  endtask

  initial begin
    int i;
    seed = 32'hcba8bd8d;
    rst_n      <= 1'b0;
    core_req   <= 1'b0;
    core_we    <= 1'b0;
    core_addr  <= '0;
    core_wdata <= '0;
    core_be    <= '0;
    vec_req    <= 1'b0;
    vec_we     <= 1'b0;
    vec_addr   <= '0;
    vec_wdata  <= '0;
    vec_be     <= '0;
    run_cnt  = 0;
    fail_cnt = 0;
    hung     = 1'b0;
    w0 = rand_word();
    w1 = rand_word();
    w2 = rand_word();
    w3 = rand_word();
    w4 = rand_word();
    w5 = rand_word();

    // name, master (0 core, 1 vec, 2 core paired with next vec), we, addr, wdata, be,
    // rdata, err, side check (1 exit, 2 APB write), side value
    add_test("arb_core_wr", 2, 1, 32'h8000_0100, w0, 8'hff, '0, 0, 0, '0);
    add_test("arb_vec_wr", 1, 1, 32'h8000_0108, w1, 8'hff, '0, 0, 0, '0);
    add_test("l2_wr_full", 0, 1, 32'h8000_0010, w2, 8'hff, '0, 0, 0, '0);
    add_test("l2_wr_part", 0, 1, 32'h8000_0010, w3, 8'h3c, '0, 0, 0, '0);
    add_test("l2_wr_top", 1, 1, 32'h8000_0ff8, w4, 8'hff, '0, 0, 0, '0);
    add_test("l2_wr_edge", 0, 1, 32'h8000_0ff8, w5, 8'h81, '0, 0, 0, '0);
    add_test("l2_rd_part", 0, 0, 32'h8000_0010, '0, 8'hff, merge_bytes(w2, w3, 8'h3c), 0, 0, '0);
    add_test("l2_rd_edge", 1, 0, 32'h8000_0ff8, '0, 8'hff, merge_bytes(w4, w5, 8'h81), 0, 0, '0);
    add_test("arb_core_rd", 0, 0, 32'h8000_0100, '0, 8'hff, w0, 0, 0, '0);
    add_test("arb_vec_rd", 1, 0, 32'h8000_0108, '0, 8'hff, w1, 0, 0, '0);
    add_test("exit_wr", 0, 1, 32'hd000_0000, 64'hdead_beef_0000_002a, 8'h0f, '0, 0, 1, 64'h2a);
    add_test("exit_rd", 0, 0, 32'hd000_0000, '0, 8'hff, 64'h2a, 0, 0, '0);
    add_test("dram_base_rd", 0, 0, 32'hd000_0008, '0, 8'hff, 64'h8000_0000, 0, 0, '0);
    add_test("dram_end_rd", 1, 0, 32'hd000_0010, '0, 8'hff, 64'h8000_1000, 0, 0, '0);
    add_test("dram_base_wr", 0, 1, 32'hd000_0008, 64'h1234, 8'hff, '0, 1, 0, '0);
    add_test("uart_wr", 0, 1, 32'hc000_0004, 64'h1122_3344_5566_7788, 8'hff, '0, 0, 2,
             {32'hc000_0004, 32'h1122_3344});
    // UART read data is the inverted paddr in both halves
    add_test("uart_rd", 1, 0, 32'hc000_0010, '0, 8'hff, {~32'hc000_0010, ~32'hc000_0010},
             0, 0, '0);
    add_test("uart_err", 1, 0, 32'hc000_0ffc, '0, 8'hff, {~32'hc000_0ffc, ~32'hc000_0ffc},
             1, 0, '0);
    add_test("unmapped_rd", 0, 0, 32'h1000_0000, '0, 8'hff, '0, 1, 0, '0);

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();

    i = 0;
    while (i < name_q.size() && !hung) begin
      if (master_q[i] == 2) begin
        run_pair(i);
        i += 2;
      end else begin
        run_one(i);
        i++;
      end
    end

    repeat (2) @(posedge clk);
    $display("Tests run: %0d, failed: %0d", run_cnt, fail_cnt);
    if (fail_cnt == 0 && !hung) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: soc_top.f
+incdir+source
source/soc_pkg.sv
source/bus_arbiter.sv
source/addr_decoder.sv
source/l2_mem.sv
source/uart_apb_bridge.sv
source/ctrl_regs.sv
source/soc_top.sv
test/apb_uart_model.sv
test/soc_top_tb.sv

// File: Bender.yml
package:
  name: soc_top

sources:
  - include_dirs:
      - source
    files:
      - source/soc_pkg.sv
      - source/bus_arbiter.sv
      - source/addr_decoder.sv
      - source/l2_mem.sv
      - source/uart_apb_bridge.sv
      - source/ctrl_regs.sv
      - source/soc_top.sv
  - target: test
    files:
      - test/apb_uart_model.sv
      - test/soc_top_tb.sv
